// ==== Bender.yml ====
package:
  name: twoopt_engine

sources:
  - include_dirs:
      - hw
    files:
      - hw/replica_pkg.sv
      - hw/distance.sv
      - hw/tour_memory.sv
      - hw/opt_sequencer.sv
      - hw/twoopt_engine.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/twoopt_engine_tb.sv

// ==== hw/distance.sv ====
`include "replica_cfg.svh"

module distance (
    input  logic                              clk,
    input  logic                              reset,

    input  logic                              dis_write,
    input  logic [2*`CITY_NUM_LOG-2:0]        dis_waddr,
    input  replica_pkg::distance_data_t       dis_wdata,

    input  logic                              opt_run,
    input  replica_pkg::opt_t                 in_opt,
    output replica_pkg::opt_t                 out_opt,
    input  replica_pkg::distance_command_t    command,

    output replica_pkg::delta_data_t          delta_distance,
    output logic [`CITY_NUM_LOG-1:0]          ordering_addr,
    input  logic [`CITY_NUM_LOG-1:0]          ordering_data
);

    localparam int DIS_DEPTH = `CITY_NUM * (`CITY_NUM + 1) / 2;
    localparam int DIS_AW    = 2 * `CITY_NUM_LOG - 1;
    localparam int PROD_W    = 2 * `CITY_NUM_LOG;
    localparam int OP_STAGES = 8;

    replica_pkg::distance_op_t   op_pipe [OP_STAGES];

    logic [`CITY_NUM_LOG-1:0]    city_cur;
    logic [`CITY_NUM_LOG-1:0]    city_prev;
    logic [`CITY_NUM_LOG-1:0]    hi_4;
    logic [`CITY_NUM_LOG-1:0]    lo_4;
    logic [PROD_W-1:0]           tri_prod;
    logic [`CITY_NUM_LOG-1:0]    lo_5;
    logic [DIS_AW-1:0]           dis_raddr;
    logic [DIS_AW-1:0]           dis_addr;
    replica_pkg::distance_data_t dis_rdata;
    replica_pkg::distance_data_t dist_l;

    replica_pkg::distance_data_t dis_ram [0:DIS_DEPTH-1];

    // current move, loaded by the sequencer.
    always_ff @(posedge clk) begin
        if (reset) begin
            out_opt.com <= replica_pkg::THR;
        end else if (opt_run) begin
            out_opt <= in_opt;
        end
    end

    // op travels alongside its data, forced idle without a move.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < OP_STAGES; i++) begin
                op_pipe[i] <= replica_pkg::DNOP;
            end
        end else begin
            if (out_opt.com == replica_pkg::THR) begin
                op_pipe[0] <= replica_pkg::DNOP;
            end else begin
                op_pipe[0] <= command.op;
            end
            for (int i = 1; i < OP_STAGES; i++) begin
                op_pipe[i] <= op_pipe[i-1];
            end
        end
    end

    // select to tour position.
    always_ff @(posedge clk) begin
        case (command.select)
            replica_pkg::KN: ordering_addr <= out_opt.K;
            replica_pkg::KP: ordering_addr <= out_opt.K + 1'b1;
            replica_pkg::KM: ordering_addr <= out_opt.K - 1'b1;
            replica_pkg::LN: ordering_addr <= out_opt.L;
            replica_pkg::LP: ordering_addr <= out_opt.L + 1'b1;
            replica_pkg::LM: ordering_addr <= out_opt.L - 1'b1;
            default:         ordering_addr <= out_opt.K;
        endcase
    end

    // pair this city with the one from the previous command.
    always_ff @(posedge clk) begin
        city_cur  <= ordering_data;
        city_prev <= city_cur;
        if (city_cur > city_prev) begin
            hi_4 <= city_cur;
            lo_4 <= city_prev;
        end else begin
            hi_4 <= city_prev;
            lo_4 <= city_cur;
        end
        tri_prod  <= PROD_W'(hi_4) * (PROD_W'(hi_4) - 1'b1);
        lo_5      <= lo_4;
        dis_raddr <= DIS_AW'(tri_prod[PROD_W-1:1]) + DIS_AW'(lo_5);
    end

    // table port is shared with loading.
    assign dis_addr = dis_write ? dis_waddr : dis_raddr;

    always_ff @(posedge clk) begin
        if (dis_write) begin
            dis_ram[dis_addr] <= dis_wdata;
        end else begin
            dis_rdata <= dis_ram[dis_addr];
        end
    end

    always_ff @(posedge clk) begin
        dist_l <= dis_rdata;
    end

    always_ff @(posedge clk) begin
        case (op_pipe[OP_STAGES-1])
            replica_pkg::ZERO: delta_distance <= '0;
            replica_pkg::PLS:  delta_distance <= delta_distance
                                                 + replica_pkg::delta_data_t'(dist_l);
            replica_pkg::MNS:  delta_distance <= delta_distance
                                                 - replica_pkg::delta_data_t'(dist_l);
            default:           delta_distance <= delta_distance;
        endcase
    end

endmodule

// ==== hw/opt_sequencer.sv ====
`include "replica_cfg.svh"

module opt_sequencer (
    input  logic                              clk,
    input  logic                              reset,

    input  logic                              req_valid,
    input  replica_pkg::opt_t                 req,
    output logic                              req_credit,

    output logic                              opt_run,
    output replica_pkg::opt_t                 opt,
    output replica_pkg::distance_command_t    command,
    input  replica_pkg::delta_data_t          delta_distance,

    output logic                              rev_start,
    output logic [`CITY_NUM_LOG-1:0]          rev_k,
    output logic [`CITY_NUM_LOG-1:0]          rev_l,
    input  logic                              rev_busy,

    output logic                              result_valid,
    output replica_pkg::opt_result_t          result
);

    localparam int PTR_W = (`REQ_DEPTH > 1) ? $clog2(`REQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(`REQ_DEPTH + 1);
    localparam logic [3:0] LAST_CMD  = 4'd8;
    localparam logic [3:0] LAST_WAIT = 4'd9;

    typedef enum logic [2:0] {
        S_IDLE,
        S_CMD,
        S_WAIT,
        S_REV,
        S_DONE
    } seq_state_t;

    replica_pkg::opt_t slots [0:`REQ_DEPTH-1];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              push;
    logic              pop;
    replica_pkg::opt_t head;
    replica_pkg::opt_t cur;

    seq_state_t        state;
    logic [3:0]        cmd_cnt;
    logic [3:0]        wait_cnt;
    logic              accept;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(`REQ_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // request without a free slot is dropped.
    assign pop  = (state == S_IDLE) && (count != '0);
    assign push = req_valid && ((count != CNT_W'(`REQ_DEPTH)) || pop);
    assign head = slots[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            slots[wr_ptr] <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign req_credit = pop;

    // pop loads TWO, done returns the register to THR.
    assign opt_run   = pop || (state == S_DONE);
    assign opt.com   = (state == S_DONE) ? replica_pkg::THR : replica_pkg::TWO;
    assign opt.K     = head.K;
    assign opt.L     = head.L;

    // four edges, each as an earlier and a later position.
    always_comb begin
        command = '{op: replica_pkg::DNOP, select: replica_pkg::KN};
        if (state == S_CMD) begin
            case (cmd_cnt)
                4'd0: command = '{op: replica_pkg::ZERO, select: replica_pkg::KN};
                4'd1: command = '{op: replica_pkg::DNOP, select: replica_pkg::KM};
                4'd2: command = '{op: replica_pkg::PLS,  select: replica_pkg::LN};
                4'd3: command = '{op: replica_pkg::DNOP, select: replica_pkg::KN};
                4'd4: command = '{op: replica_pkg::PLS,  select: replica_pkg::LP};
                4'd5: command = '{op: replica_pkg::DNOP, select: replica_pkg::KM};
                4'd6: command = '{op: replica_pkg::MNS,  select: replica_pkg::KN};
                4'd7: command = '{op: replica_pkg::DNOP, select: replica_pkg::LN};
                4'd8: command = '{op: replica_pkg::MNS,  select: replica_pkg::LP};
                default: begin
                end
            endcase
        end
    end

    assign accept = delta_distance[`DELTA_W-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= S_IDLE;
            cmd_cnt      <= '0;
            wait_cnt     <= '0;
            result_valid <= 1'b0;
            rev_start    <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            rev_start    <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (pop) begin
                        state   <= S_CMD;
                        cmd_cnt <= '0;
                    end
                end
                S_CMD: begin
                    if (cmd_cnt == LAST_CMD) begin
                        state    <= S_WAIT;
                        wait_cnt <= '0;
                    end else begin
                        cmd_cnt <= cmd_cnt + 1'b1;
                    end
                end
                S_WAIT: begin
                    // delta has settled by now.
                    if (wait_cnt == LAST_WAIT) begin
                        result_valid <= 1'b1;
                        rev_start    <= accept;
                        state        <= accept ? S_REV : S_DONE;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                S_REV: begin
                    // busy rises one cycle after the start pulse.
                    if (!rev_start && !rev_busy) begin
                        state <= S_DONE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            cur <= head;
        end
        if (state == S_WAIT && wait_cnt == LAST_WAIT) begin
            result <= '{K: cur.K, L: cur.L, delta: delta_distance, accepted: accept};
        end
    end

    assign rev_k = cur.K;
    assign rev_l = cur.L;

endmodule

// ==== hw/replica_cfg.svh ====
`ifndef REPLICA_CFG_SVH
`define REPLICA_CFG_SVH

// cities in one tour.
`define CITY_NUM 16

// bits of a city number or a tour position.
`define CITY_NUM_LOG 4

// bits of one distance table entry.
`define DIST_W 12

// bits of the signed tour length change.
`define DELTA_W 16

// request queue slots, same as the host credits after reset.
`define REQ_DEPTH 2

`endif

// ==== hw/replica_pkg.sv ====
`include "replica_cfg.svh"

package replica_pkg;

    // kind of move held in the opt register.
    typedef enum logic {
        THR,
        TWO
    } opt_com_t;

    typedef struct packed {
        opt_com_t                 com;
        logic [`CITY_NUM_LOG-1:0] K;
        logic [`CITY_NUM_LOG-1:0] L;
    } opt_t;

    // accumulator operation.
    typedef enum logic [1:0] {
        DNOP,
        ZERO,
        PLS,
        MNS
    } distance_op_t;

    // tour position around K or L.
    typedef enum logic [2:0] {
        KN,
        KP,
        KM,
        LN,
        LP,
        LM
    } select_t;

    typedef struct packed {
        distance_op_t op;
        select_t      select;
    } distance_command_t;

    typedef logic [`DIST_W-1:0] distance_data_t;

    typedef logic signed [`DELTA_W-1:0] delta_data_t;

    typedef struct packed {
        logic [`CITY_NUM_LOG-1:0] K;
        logic [`CITY_NUM_LOG-1:0] L;
        delta_data_t              delta;
        logic                     accepted;
    } opt_result_t;

endpackage

// ==== hw/tour_memory.sv ====
`include "replica_cfg.svh"

module tour_memory (
    input  logic                     clk,
    input  logic                     reset,

    input  logic                     tour_write,
    input  logic [`CITY_NUM_LOG-1:0] tour_waddr,
    input  logic [`CITY_NUM_LOG-1:0] tour_wdata,

    input  logic [`CITY_NUM_LOG-1:0] ordering_addr,
    output logic [`CITY_NUM_LOG-1:0] ordering_data,

    input  logic                     rev_start,
    input  logic [`CITY_NUM_LOG-1:0] rev_k,
    input  logic [`CITY_NUM_LOG-1:0] rev_l,
    output logic                     rev_busy
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_RD,
        S_WR,
        S_FIN
    } rev_state_t;

    rev_state_t               state;
    logic [`CITY_NUM_LOG-1:0] lo_ptr;
    logic [`CITY_NUM_LOG-1:0] hi_ptr;
    logic                     pend;

    logic [`CITY_NUM_LOG-1:0] rd_addr;
    logic [`CITY_NUM_LOG-1:0] rdata;
    logic                     wr_en;
    logic [`CITY_NUM_LOG-1:0] wr_addr;
    logic [`CITY_NUM_LOG-1:0] wr_data;

    logic [`CITY_NUM_LOG-1:0] tour_ram [0:`CITY_NUM-1];

    // reversal owns both ports while busy.
    always_comb begin
        rd_addr = ordering_addr;
        wr_en   = tour_write;
        wr_addr = tour_waddr;
        wr_data = tour_wdata;
        case (state)
            S_RD: begin
                // finish the previous pair on the low side.
                rd_addr = lo_ptr;
                wr_en   = pend;
                wr_addr = lo_ptr - 1'b1;
                wr_data = rdata;
            end
            S_WR: begin
                rd_addr = hi_ptr;
                wr_en   = 1'b1;
                wr_addr = hi_ptr;
                wr_data = rdata;
            end
            S_FIN: begin
                rd_addr = lo_ptr;
                wr_en   = 1'b1;
                wr_addr = lo_ptr - 1'b1;
                wr_data = rdata;
            end
            default: begin
            end
        endcase
    end

    // read returns the old entry on a same-address write.
    always_ff @(posedge clk) begin
        rdata <= tour_ram[rd_addr];
        if (wr_en) begin
            tour_ram[wr_addr] <= wr_data;
        end
    end

    assign ordering_data = rdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
            pend  <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (rev_start) begin
                        state <= S_RD;
                        pend  <= 1'b0;
                    end
                end
                S_RD: begin
                    state <= S_WR;
                end
                S_WR: begin
                    pend <= 1'b1;
                    if ({1'b0, lo_ptr} + 5'd2 < {1'b0, hi_ptr}) begin
                        state <= S_RD;
                    end else begin
                        state <= S_FIN;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // pointers move inward after each pair.
    always_ff @(posedge clk) begin
        if (state == S_IDLE && rev_start) begin
            lo_ptr <= rev_k;
            hi_ptr <= rev_l;
        end else if (state == S_WR) begin
            lo_ptr <= lo_ptr + 1'b1;
            hi_ptr <= hi_ptr - 1'b1;
        end
    end

    assign rev_busy = (state != S_IDLE);

endmodule

// ==== hw/twoopt_engine.sv ====
`include "replica_cfg.svh"

module twoopt_engine (
    input  logic                        clk,
    input  logic                        reset,

    input  logic                        dis_write,
    input  logic [2*`CITY_NUM_LOG-2:0]  dis_waddr,
    input  replica_pkg::distance_data_t dis_wdata,

    input  logic                        tour_write,
    input  logic [`CITY_NUM_LOG-1:0]    tour_waddr,
    input  logic [`CITY_NUM_LOG-1:0]    tour_wdata,

    input  logic                        req_valid,
    input  replica_pkg::opt_t           req,
    output logic                        req_credit,

    output logic                        result_valid,
    output replica_pkg::opt_result_t    result
);

    logic                           opt_run;
    replica_pkg::opt_t              opt;
    replica_pkg::distance_command_t command;
    replica_pkg::delta_data_t       delta_distance;
    logic [`CITY_NUM_LOG-1:0]       ordering_addr;
    logic [`CITY_NUM_LOG-1:0]       ordering_data;
    logic                           rev_start;
    logic [`CITY_NUM_LOG-1:0]       rev_k;
    logic [`CITY_NUM_LOG-1:0]       rev_l;
    logic                           rev_busy;

    // held move is only needed inside the distance unit.
    distance distance_inst (
        .clk            (clk),
        .reset          (reset),
        .dis_write      (dis_write),
        .dis_waddr      (dis_waddr),
        .dis_wdata      (dis_wdata),
        .opt_run        (opt_run),
        .in_opt         (opt),
        .out_opt        (),
        .command        (command),
        .delta_distance (delta_distance),
        .ordering_addr  (ordering_addr),
        .ordering_data  (ordering_data)
    );

    tour_memory tour_memory_inst (
        .clk           (clk),
        .reset         (reset),
        .tour_write    (tour_write),
        .tour_waddr    (tour_waddr),
        .tour_wdata    (tour_wdata),
        .ordering_addr (ordering_addr),
        .ordering_data (ordering_data),
        .rev_start     (rev_start),
        .rev_k         (rev_k),
        .rev_l         (rev_l),
        .rev_busy      (rev_busy)
    );

    opt_sequencer opt_sequencer_inst (
        .clk            (clk),
        .reset          (reset),
        .req_valid      (req_valid),
        .req            (req),
        .req_credit     (req_credit),
        .opt_run        (opt_run),
        .opt            (opt),
        .command        (command),
        .delta_distance (delta_distance),
        .rev_start      (rev_start),
        .rev_k          (rev_k),
        .rev_l          (rev_l),
        .rev_busy       (rev_busy),
        .result_valid   (result_valid),
        .result         (result)
    );

endmodule

// ==== twoopt_engine.f ====
+incdir+hw
hw/replica_pkg.sv
hw/distance.sv
hw/tour_memory.sv
hw/opt_sequencer.sv
hw/twoopt_engine.sv
verif/twoopt_engine_tb.sv

// ==== verif/twoopt_engine_tb.sv ====
`include "replica_cfg.svh"

module twoopt_engine_tb;
    timeunit 1ns;
    timeprecision 1ns;

    localparam int N_CITY      = `CITY_NUM;
    localparam int IDX_W       = `CITY_NUM_LOG;
    localparam int DIS_AW      = 2 * IDX_W - 1;
    localparam int REQ_DEPTH   = `REQ_DEPTH;
    localparam int N_REQ       = 40;
    localparam int LOAD_CYCLES = 10 + N_CITY * (N_CITY - 1) / 2 + N_CITY + 16;
    localparam int CYCLE_LIMIT = N_REQ * (20 + 2 * N_CITY) + LOAD_CYCLES;

    logic                        clk;
    logic                        reset;
    logic                        dis_write;
    logic [DIS_AW-1:0]           dis_waddr;
    replica_pkg::distance_data_t dis_wdata;
    logic                        tour_write;
    logic [IDX_W-1:0]            tour_waddr;
    logic [IDX_W-1:0]            tour_wdata;
    logic                        req_valid;
    replica_pkg::opt_t           req;
    logic                        req_credit;
    logic                        result_valid;
    replica_pkg::opt_result_t    result;

    logic [31:0]       lfsr_state;
    int                dist_m [N_CITY][N_CITY];
    int                tour_m [N_CITY];
    replica_pkg::opt_t req_list [N_REQ];
    replica_pkg::opt_t sent_q [$];
    int                credits;
    int                sent_count;
    int                results_rcvd;
    int                cycle_count;

    twoopt_engine twoopt_engine_inst (
        .clk          (clk),
        .reset        (reset),
        .dis_write    (dis_write),
        .dis_waddr    (dis_waddr),
        .dis_wdata    (dis_wdata),
        .tour_write   (tour_write),
        .tour_waddr   (tour_waddr),
        .tour_wdata   (tour_wdata),
        .req_valid    (req_valid),
        .req          (req),
        .req_credit   (req_credit),
        .result_valid (result_valid),
        .result       (result)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic int random_bits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
        return value;
    endfunction

    task automatic check_value(input string name, input longint got, input longint expected);
        if (got != expected) begin
            $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, expected);
            $display("** FAIL **");
            $fatal(1, "value mismatch");
        end
    endtask

    // two edges in, two edges out.
    function automatic int model_delta(input int k, input int l);
        int a;
        int b;
        int c;
        int d;
        a = tour_m[k-1];
        b = tour_m[k];
        c = tour_m[l];
        d = tour_m[l+1];
        return dist_m[a][c] + dist_m[b][d] - dist_m[a][b] - dist_m[c][d];
    endfunction

    task automatic reverse_model(input int k, input int l);
        int tmp;
        while (k < l) begin
            tmp       = tour_m[k];
            tour_m[k] = tour_m[l];
            tour_m[l] = tmp;
            k++;
            l--;
        end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout, only %0d of %0d results arrived", results_rcvd, N_REQ);
            $display("** FAIL **");
            $fatal(1, "timeout");
        end
    end

    // outputs are stable mid cycle.
    always @(negedge clk) begin
        replica_pkg::opt_t exp_req;
        int exp_delta;
        int got_delta;
        if (!reset) begin
            if (sent_count == 0) begin
                check_value("result_valid", result_valid, 0);
                check_value("req_credit", req_credit, 0);
            end
            if (req_credit) begin
                credits++;
                check_value("credits_within_depth", credits <= REQ_DEPTH, 1);
            end
            if (result_valid && sent_q.size() == 0) begin
                $display("a result arrived with no request outstanding");
                $display("** FAIL **");
                $fatal(1, "extra result");
            end else if (result_valid) begin
                exp_req   = sent_q.pop_front();
                exp_delta = model_delta(exp_req.K, exp_req.L);
                got_delta = $signed(result.delta);
                check_value("result.K", result.K, exp_req.K);
                check_value("result.L", result.L, exp_req.L);
                check_value("result.delta", got_delta, exp_delta);
                check_value("result.accepted", result.accepted, exp_delta < 0);
                if (exp_delta < 0) begin
                    reverse_model(exp_req.K, exp_req.L);
                end
                results_rcvd++;
            end
        end
    end

    initial begin
        int k;
        int l;
        int j;
        int tmp;
        int gap;
        reset        = 1'b1;
        dis_write    = 1'b0;
        dis_waddr    = '0;
        dis_wdata    = '0;
        tour_write   = 1'b0;
        tour_waddr   = '0;
        tour_wdata   = '0;
        req_valid    = 1'b0;
        req          = '0;
        lfsr_state   = 32'hd2f3;
        credits      = REQ_DEPTH;
        sent_count   = 0;
        results_rcvd = 0;
        cycle_count  = 0;

        // symmetric table, zero diagonal.
        for (int i = 0; i < N_CITY; i++) begin
            dist_m[i][i] = 0;
            for (int m = 0; m < i; m++) begin
                dist_m[i][m] = random_bits(`DIST_W);
                dist_m[m][i] = dist_m[i][m];
            end
        end
        for (int i = 0; i < N_CITY; i++) begin
            tour_m[i] = i;
        end
        for (int i = N_CITY - 1; i > 0; i--) begin
            j         = random_bits(IDX_W) % (i + 1);
            tmp       = tour_m[i];
            tour_m[i] = tour_m[j];
            tour_m[j] = tmp;
        end
        for (int n = 0; n < N_REQ; n++) begin
            k = 0;
            while (k < 1 || k > N_CITY - 3) begin
                k = random_bits(IDX_W);
            end
            l = 0;
            while (l <= k || l > N_CITY - 2) begin
                l = random_bits(IDX_W);
            end
            req_list[n].com = replica_pkg::TWO;
            req_list[n].K   = k[IDX_W-1:0];
            req_list[n].L   = l[IDX_W-1:0];
        end

        repeat (10) @(posedge clk);
        #10 reset = 1'b0;

        for (int i = 1; i < N_CITY; i++) begin
            for (int m = 0; m < i; m++) begin
                @(posedge clk);
                #10;
                dis_write = 1'b1;
                dis_waddr = DIS_AW'(i * (i - 1) / 2 + m);
                dis_wdata = dist_m[i][m];
            end
        end
        @(posedge clk);
        #10 dis_write = 1'b0;
        for (int i = 0; i < N_CITY; i++) begin
            @(posedge clk);
            #10;
            tour_write = 1'b1;
            tour_waddr = i[IDX_W-1:0];
            tour_wdata = tour_m[i][IDX_W-1:0];
        end
        @(posedge clk);
        #10 tour_write = 1'b0;
        repeat (8) @(posedge clk);

        // host sends only while it holds a credit.
        gap = 0;
        while (sent_count < N_REQ) begin
            @(posedge clk);
            #10;
            if (gap == 0 && credits > 0) begin
                req_valid = 1'b1;
                req       = req_list[sent_count];
                sent_q.push_back(req_list[sent_count]);
                sent_count++;
                credits--;
                gap = random_bits(2);
            end else begin
                req_valid = 1'b0;
                if (gap > 0) begin
                    gap--;
                end
            end
        end
        @(posedge clk);
        #10 req_valid = 1'b0;

        while (results_rcvd < N_REQ) begin
            @(posedge clk);
        end
        repeat (64) @(posedge clk);
        check_value("credits_returned", credits, REQ_DEPTH);
        $display("** PASS **");
        $finish;
    end

endmodule
